/* dcache_macros.svh */
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address and data widths
`define DC_ADDR_W     32
`define DC_WORD_W     64

// cache geometry, 4 KiB in two ways
`define DC_LINE_BYTES 32
`define DC_SETS       64
`define DC_WAYS       2

// one line moves as a burst of this many words
`define DC_BEATS      4

// address split {tag, index, offset}
`define DC_OFFT_W     5
`define DC_INDEX_W    6
`define DC_TAG_W      21

`endif

/* dcache_geom_pkg.sv */
`default_nettype none

`include "dcache_macros.svh"

package dcache_geom_pkg;

    // address fields
    typedef logic [`DC_TAG_W-1:0]   tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;

    // word position inside a line
    typedef logic [$clog2(`DC_BEATS)-1:0] word_sel_t;

    // data payloads
    typedef logic [`DC_WORD_W-1:0]       word_t;
    typedef logic [`DC_WORD_W/8-1:0]     wmask_t;
    typedef logic [`DC_LINE_BYTES*8-1:0] line_t;

    typedef logic [$clog2(`DC_WAYS)-1:0] way_t;

endpackage

`default_nettype wire

/* dcache_bus_pkg.sv */
`default_nettype none

`include "dcache_macros.svh"

package dcache_bus_pkg;

    typedef logic [`DC_ADDR_W-1:0]        addr_t;
    typedef logic [$clog2(`DC_BEATS)-1:0] beat_cnt_t;

    // write-back sequencer, one-hot
    typedef enum logic [3:0] {
        WB_IDLE = 4'b0001,
        WB_ADDR = 4'b0010,
        WB_DATA = 4'b0100,
        WB_RESP = 4'b1000
    } wb_state_t;

endpackage

`default_nettype wire

/* dcache_data_array.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_data_array (
    input  logic                    I_clk,
    input  logic                    rd_en,
    input  dcache_geom_pkg::way_t   rd_way,
    input  dcache_geom_pkg::index_t rd_index,
    output dcache_geom_pkg::line_t  rd_line,
    input  logic                    wr_en,
    input  dcache_geom_pkg::way_t   wr_way,
    input  dcache_geom_pkg::index_t wr_index,
    input  dcache_geom_pkg::line_t  wr_line
);

    // entry address is {index, way}
    dcache_geom_pkg::line_t mem_q [`DC_SETS*`DC_WAYS];

    always_ff @(posedge I_clk) begin
        if (wr_en) begin
            mem_q[{wr_index, wr_way}] <= wr_line;
        end
    end

    // registered read, old data on a same-entry write
    always_ff @(posedge I_clk) begin
        if (rd_en) begin
            rd_line <= mem_q[{rd_index, rd_way}];
        end
    end

endmodule

`default_nettype wire

/* dcache_tag_store.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_tag_store (
    input  logic                    I_clk,
    input  logic                    I_rst,
    input  dcache_geom_pkg::tag_t   lookup_tag,
    input  dcache_geom_pkg::index_t lookup_index,
    output logic                    hit,
    output dcache_geom_pkg::way_t   hit_way,
    output dcache_geom_pkg::way_t   victim_way,
    output logic                    victim_dirty,
    output dcache_geom_pkg::tag_t   victim_tag,
    input  logic                    tag_alloc,
    input  logic                    dirty_set,
    input  dcache_geom_pkg::index_t upd_index,
    input  dcache_geom_pkg::tag_t   upd_tag,
    input  dcache_geom_pkg::way_t   upd_way
);

    dcache_geom_pkg::tag_t            tag_q [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] valid_q;
    logic [`DC_WAYS-1:0][`DC_SETS-1:0] dirty_q;
    logic                              hit0;
    logic                              hit1;

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign hit0    = valid_q[0][lookup_index] && (tag_q[0][lookup_index] == lookup_tag);
    assign hit1    = valid_q[1][lookup_index] && (tag_q[1][lookup_index] == lookup_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    // fill an empty way 1 first, otherwise replace way 0
    assign victim_way = hit ? hit_way
                            : (valid_q[0][lookup_index] && !valid_q[1][lookup_index]);

    assign victim_dirty = dirty_q[victim_way][lookup_index];
    assign victim_tag   = tag_q[victim_way][lookup_index];

    ////////////////////////////////////////////////////////////
    // table updates
    ////////////////////////////////////////////////////////////

    always_ff @(posedge I_clk) begin
        if (tag_alloc) begin
            tag_q[upd_way][upd_index] <= upd_tag;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (tag_alloc) begin
            valid_q[upd_way][upd_index] <= 1'b1;
            dirty_q[upd_way][upd_index] <= dirty_set;
        end else if (dirty_set) begin
            dirty_q[upd_way][upd_index] <= 1'b1;
        end
    end

    // a line is never held in both ways of a set
    assert property (@(posedge I_clk) disable iff (I_rst) !(hit0 && hit1));

endmodule

`default_nettype wire

/* dcache_line_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_line_buffer (
    input  logic                       I_clk,
    input  logic                       I_rst,
    input  dcache_geom_pkg::word_t     mem_rdata,
    input  logic                       mem_rvalid,
    input  logic                       load_hit,
    input  dcache_geom_pkg::line_t     hit_line,
    input  logic                       capture,
    input  logic                       merge,
    input  dcache_geom_pkg::word_t     cpu_wdata,
    input  dcache_geom_pkg::wmask_t    cpu_wmask,
    input  dcache_geom_pkg::word_sel_t word_sel,
    output dcache_geom_pkg::line_t     line,
    output dcache_geom_pkg::word_t     word
);

    dcache_geom_pkg::line_t  line_q;
    dcache_geom_pkg::line_t  src;
    dcache_geom_pkg::line_t  merged;
    dcache_geom_pkg::word_t  wdata_q;
    dcache_geom_pkg::wmask_t wmask_q;

    // store data held from acceptance until the merge
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            wmask_q <= '0;
        end else if (capture) begin
            wmask_q <= cpu_wmask;
        end
    end

    always_ff @(posedge I_clk) begin
        if (capture) begin
            wdata_q <= cpu_wdata;
        end
    end

    // array line on a hit, assembled line otherwise
    assign src = load_hit ? hit_line : line_q;

    always_comb begin
        merged = src;
        for (int b = 0; b < `DC_WORD_W/8; b++) begin
            if (wmask_q[b]) begin
                merged[word_sel*`DC_WORD_W + b*8 +: 8] = wdata_q[b*8 +: 8];
            end
        end
    end

    assign line = merge ? merged : src;
    assign word = src[word_sel*`DC_WORD_W +: `DC_WORD_W];

    // reload beats enter at the top, lowest word ends at bit 0
    always_ff @(posedge I_clk) begin
        if (mem_rvalid) begin
            line_q <= {mem_rdata, line_q[$bits(line_q)-1:`DC_WORD_W]};
        end else if (load_hit || merge) begin
            line_q <= line;
        end
    end

endmodule

`default_nettype wire

/* dcache_wb_engine.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_wb_engine (
    input  logic                   I_clk,
    input  logic                   I_rst,
    input  logic                   start,
    input  dcache_geom_pkg::line_t victim_line,
    input  dcache_bus_pkg::addr_t  victim_addr,
    output dcache_bus_pkg::addr_t  mem_awaddr,
    output logic                   mem_awvalid,
    input  logic                   mem_awready,
    output dcache_geom_pkg::word_t mem_wdata,
    output logic                   mem_wvalid,
    output logic                   mem_wlast,
    input  logic                   mem_wready,
    input  logic                   mem_bvalid,
    output logic                   done
);

    dcache_bus_pkg::wb_state_t state_q;
    dcache_bus_pkg::beat_cnt_t cnt_q;
    dcache_geom_pkg::line_t    line_q;
    dcache_bus_pkg::addr_t     addr_q;

    // victim copy, the array entry gets overwritten by the allocate
    always_ff @(posedge I_clk) begin
        if (start && state_q == dcache_bus_pkg::WB_IDLE) begin
            line_q <= victim_line;
            addr_q <= victim_addr;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state_q <= dcache_bus_pkg::WB_IDLE;
            cnt_q   <= '0;
        end else begin
            unique case (state_q)
                dcache_bus_pkg::WB_IDLE: begin
                    cnt_q <= '0;
                    if (start) begin
                        state_q <= dcache_bus_pkg::WB_ADDR;
                    end
                end
                dcache_bus_pkg::WB_ADDR: begin
                    if (mem_awready) begin
                        state_q <= dcache_bus_pkg::WB_DATA;
                    end
                end
                dcache_bus_pkg::WB_DATA: begin
                    if (mem_wready) begin
                        cnt_q <= cnt_q + 1'b1;
                        if (mem_wlast) begin
                            state_q <= dcache_bus_pkg::WB_RESP;
                        end
                    end
                end
                default: begin
                    if (mem_bvalid) begin
                        state_q <= dcache_bus_pkg::WB_IDLE;
                    end
                end
            endcase
        end
    end

    assign mem_awaddr  = addr_q;
    assign mem_awvalid = (state_q == dcache_bus_pkg::WB_ADDR);
    assign mem_wvalid  = (state_q == dcache_bus_pkg::WB_DATA);
    assign mem_wdata   = line_q[cnt_q*`DC_WORD_W +: `DC_WORD_W];
    assign mem_wlast   = mem_wvalid && (cnt_q == dcache_bus_pkg::beat_cnt_t'(`DC_BEATS-1));
    assign done        = (state_q == dcache_bus_pkg::WB_RESP) && mem_bvalid;

    // a new victim only arrives once the previous burst is done
    assert property (@(posedge I_clk) disable iff (I_rst)
        start |-> (state_q == dcache_bus_pkg::WB_IDLE));

endmodule

`default_nettype wire

/* dcache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "dcache_macros.svh"

module dcache_ctrl (
    input  logic                       I_clk,
    input  logic                       I_rst,
    input  dcache_bus_pkg::addr_t      cpu_addr,
    input  logic                       cpu_rd_req,
    input  logic                       cpu_wr_req,
    output logic                       cpu_ready,
    output logic                       cpu_rvalid,
    output logic                       cpu_bvalid,
    input  logic                       hit,
    input  dcache_geom_pkg::way_t      hit_way,
    input  dcache_geom_pkg::way_t      victim_way,
    input  logic                       victim_dirty,
    input  dcache_geom_pkg::tag_t      victim_tag,
    output logic                       tag_alloc,
    output logic                       dirty_set,
    output dcache_geom_pkg::index_t    req_index,
    output dcache_geom_pkg::tag_t      req_tag,
    output dcache_geom_pkg::way_t      op_way,
    output logic                       arr_rd_en,
    output logic                       arr_wr_en,
    output dcache_geom_pkg::index_t    arr_index,
    output dcache_geom_pkg::way_t      arr_way,
    output logic                       buf_load_hit,
    output logic                       buf_merge,
    output logic                       buf_capture,
    output dcache_geom_pkg::word_sel_t word_sel,
    output dcache_bus_pkg::addr_t      mem_araddr,
    output logic                       mem_arvalid,
    input  logic                       mem_arready,
    input  logic                       mem_rvalid,
    input  logic                       mem_rlast,
    output logic                       wb_start,
    output dcache_bus_pkg::addr_t      wb_addr,
    input  logic                       wb_done
);

    typedef enum logic [2:0] {
        IDLE, RD_HIT, WR_HIT, MISS_AR, RELOAD, WB, ALLOCATE
    } state_t;

    state_t                  state_q;
    state_t                  state_d;
    dcache_bus_pkg::addr_t   addr_q;
    dcache_geom_pkg::way_t   way_q;
    logic                    is_wr_q;
    logic                    wb_start_q;
    logic                    idle;
    logic                    accept;
    logic                    last_beat;
    dcache_geom_pkg::tag_t   q_tag;
    dcache_geom_pkg::index_t q_index;

    assign idle      = (state_q == IDLE);
    assign accept    = idle && (cpu_rd_req || cpu_wr_req);
    assign last_beat = (state_q == RELOAD) && mem_rvalid && mem_rlast;

    assign q_tag   = addr_q[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign q_index = addr_q[`DC_OFFT_W +: `DC_INDEX_W];

    ////////////////////////////////////////////////////////////
    // request capture
    ////////////////////////////////////////////////////////////

    // way chosen at acceptance, hit way or victim
    always_ff @(posedge I_clk) begin
        if (accept) begin
            addr_q <= cpu_addr;
            way_q  <= victim_way;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state_q    <= IDLE;
            is_wr_q    <= 1'b0;
            wb_start_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            // victim line is out of the array one cycle after rlast
            wb_start_q <= last_beat && victim_dirty;
            if (accept) begin
                is_wr_q <= cpu_wr_req;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (accept) begin
                    if (hit) begin
                        state_d = cpu_wr_req ? WR_HIT : RD_HIT;
                    end else begin
                        state_d = MISS_AR;
                    end
                end
            end
            RD_HIT, WR_HIT: state_d = IDLE;
            MISS_AR: begin
                if (mem_arready) begin
                    state_d = RELOAD;
                end
            end
            // reload first, then write back a dirty victim
            RELOAD: begin
                if (last_beat) begin
                    state_d = victim_dirty ? WB : ALLOCATE;
                end
            end
            WB: begin
                if (wb_done) begin
                    state_d = ALLOCATE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // lookup follows the live address only while idle
    assign req_tag   = idle ? cpu_addr[`DC_ADDR_W-1 -: `DC_TAG_W] : q_tag;
    assign req_index = idle ? cpu_addr[`DC_OFFT_W +: `DC_INDEX_W] : q_index;
    assign op_way    = way_q;

    assign cpu_ready  = idle;
    assign cpu_rvalid = (state_q == RD_HIT) || (state_q == ALLOCATE && !is_wr_q);
    assign cpu_bvalid = (state_q == WR_HIT) || (state_q == ALLOCATE && is_wr_q);

    assign tag_alloc = (state_q == ALLOCATE);
    assign dirty_set = cpu_bvalid;

    assign arr_rd_en = (accept && hit) || last_beat;
    assign arr_wr_en = (state_q == WR_HIT) || (state_q == ALLOCATE);
    assign arr_index = req_index;
    assign arr_way   = idle ? hit_way : way_q;

    assign buf_load_hit = (state_q == RD_HIT) || (state_q == WR_HIT);
    assign buf_merge    = cpu_bvalid;
    assign buf_capture  = accept && cpu_wr_req;
    assign word_sel     = addr_q[`DC_OFFT_W-1:3];

    assign mem_arvalid = (state_q == MISS_AR);
    assign mem_araddr  = {q_tag, q_index, {`DC_OFFT_W{1'b0}}};

    assign wb_start = wb_start_q;
    assign wb_addr  = {victim_tag, q_index, {`DC_OFFT_W{1'b0}}};

    // write-back completes only while the FSM waits for it
    assert property (@(posedge I_clk) disable iff (I_rst) wb_done |-> (state_q == WB));

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module dcache_top (
    input  logic                    I_clk,
    input  logic                    I_rst,
    input  dcache_bus_pkg::addr_t   cpu_addr,
    input  dcache_geom_pkg::word_t  cpu_wdata,
    input  dcache_geom_pkg::wmask_t cpu_wmask,
    input  logic                    cpu_rd_req,
    input  logic                    cpu_wr_req,
    output logic                    cpu_ready,
    output logic                    cpu_rvalid,
    output logic                    cpu_bvalid,
    output dcache_geom_pkg::word_t  cpu_rdata,
    output dcache_bus_pkg::addr_t   mem_araddr,
    output logic                    mem_arvalid,
    input  logic                    mem_arready,
    input  dcache_geom_pkg::word_t  mem_rdata,
    input  logic                    mem_rvalid,
    input  logic                    mem_rlast,
    output dcache_bus_pkg::addr_t   mem_awaddr,
    output logic                    mem_awvalid,
    input  logic                    mem_awready,
    output dcache_geom_pkg::word_t  mem_wdata,
    output logic                    mem_wvalid,
    output logic                    mem_wlast,
    input  logic                    mem_wready,
    input  logic                    mem_bvalid
);

    logic                       hit;
    dcache_geom_pkg::way_t      hit_way;
    dcache_geom_pkg::way_t      victim_way;
    logic                       victim_dirty;
    dcache_geom_pkg::tag_t      victim_tag;
    logic                       tag_alloc;
    logic                       dirty_set;
    dcache_geom_pkg::index_t    req_index;
    dcache_geom_pkg::tag_t      req_tag;
    dcache_geom_pkg::way_t      op_way;
    logic                       arr_rd_en;
    logic                       arr_wr_en;
    dcache_geom_pkg::index_t    arr_index;
    dcache_geom_pkg::way_t      arr_way;
    dcache_geom_pkg::line_t     rd_line;
    logic                       buf_load_hit;
    logic                       buf_merge;
    logic                       buf_capture;
    dcache_geom_pkg::word_sel_t word_sel;
    dcache_geom_pkg::line_t     buf_line;
    logic                       wb_start;
    dcache_bus_pkg::addr_t      wb_addr;
    logic                       wb_done;

    dcache_ctrl dcache_ctrl_inst (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .cpu_addr     (cpu_addr),
        .cpu_rd_req   (cpu_rd_req),
        .cpu_wr_req   (cpu_wr_req),
        .cpu_ready    (cpu_ready),
        .cpu_rvalid   (cpu_rvalid),
        .cpu_bvalid   (cpu_bvalid),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .tag_alloc    (tag_alloc),
        .dirty_set    (dirty_set),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .op_way       (op_way),
        .arr_rd_en    (arr_rd_en),
        .arr_wr_en    (arr_wr_en),
        .arr_index    (arr_index),
        .arr_way      (arr_way),
        .buf_load_hit (buf_load_hit),
        .buf_merge    (buf_merge),
        .buf_capture  (buf_capture),
        .word_sel     (word_sel),
        .mem_araddr   (mem_araddr),
        .mem_arvalid  (mem_arvalid),
        .mem_arready  (mem_arready),
        .mem_rvalid   (mem_rvalid),
        .mem_rlast    (mem_rlast),
        .wb_start     (wb_start),
        .wb_addr      (wb_addr),
        .wb_done      (wb_done)
    );

    // lookup and update share the request address
    dcache_tag_store dcache_tag_store_inst (
        .I_clk        (I_clk),
        .I_rst        (I_rst),
        .lookup_tag   (req_tag),
        .lookup_index (req_index),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .tag_alloc    (tag_alloc),
        .dirty_set    (dirty_set),
        .upd_index    (req_index),
        .upd_tag      (req_tag),
        .upd_way      (op_way)
    );

    dcache_data_array dcache_data_array_inst (
        .I_clk    (I_clk),
        .rd_en    (arr_rd_en),
        .rd_way   (arr_way),
        .rd_index (arr_index),
        .rd_line  (rd_line),
        .wr_en    (arr_wr_en),
        .wr_way   (arr_way),
        .wr_index (arr_index),
        .wr_line  (buf_line)
    );

    dcache_line_buffer dcache_line_buffer_inst (
        .I_clk      (I_clk),
        .I_rst      (I_rst),
        .mem_rdata  (mem_rdata),
        .mem_rvalid (mem_rvalid),
        .load_hit   (buf_load_hit),
        .hit_line   (rd_line),
        .capture    (buf_capture),
        .merge      (buf_merge),
        .cpu_wdata  (cpu_wdata),
        .cpu_wmask  (cpu_wmask),
        .word_sel   (word_sel),
        .line       (buf_line),
        .word       (cpu_rdata)
    );

    dcache_wb_engine dcache_wb_engine_inst (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .start       (wb_start),
        .victim_line (rd_line),
        .victim_addr (wb_addr),
        .mem_awaddr  (mem_awaddr),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_wdata   (mem_wdata),
        .mem_wvalid  (mem_wvalid),
        .mem_wlast   (mem_wlast),
        .mem_wready  (mem_wready),
        .mem_bvalid  (mem_bvalid),
        .done        (wb_done)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic I_clk,
    output logic I_rst
);

    // 10 ns period
    initial begin
        I_clk = 1'b0;
        forever #5 I_clk = ~I_clk;
    end

    // reset held for 4 rising edges, released on a falling edge
    initial begin
        I_rst = 1'b1;
        repeat (4) @(posedge I_clk);
        @(negedge I_clk);
        I_rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_dcache;

    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        rst;
    logic [31:0] cpu_addr;
    logic [63:0] cpu_wdata;
    logic [7:0]  cpu_wmask;
    logic        cpu_rd_req;
    logic        cpu_wr_req;
    logic        cpu_ready;
    logic        cpu_rvalid;
    logic        cpu_bvalid;
    logic [63:0] cpu_rdata;
    logic [31:0] mem_araddr;
    logic        mem_arvalid;
    logic        mem_arready;
    logic [63:0] mem_rdata;
    logic        mem_rvalid;
    logic        mem_rlast;
    logic [31:0] mem_awaddr;
    logic        mem_awvalid;
    logic        mem_awready;
    logic [63:0] mem_wdata;
    logic        mem_wvalid;
    logic        mem_wlast;
    logic        mem_wready;
    logic        mem_bvalid;

    // byte models, absent entries hold the init hash
    logic [7:0]  model_mem [int unsigned];
    logic [7:0]  bus_mem [int unsigned];
    bit          touched [int unsigned];

    logic [31:0] stim_seed;
    logic [31:0] mem_seed;
    int          wb_count;
    logic [31:0] last_wb_addr;

    tb_clock_gen tb_clock_gen_inst (
        .I_clk (clk),
        .I_rst (rst)
    );

    dcache_top dcache_top_inst (
        .I_clk       (clk),
        .I_rst       (rst),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_wmask   (cpu_wmask),
        .cpu_rd_req  (cpu_rd_req),
        .cpu_wr_req  (cpu_wr_req),
        .cpu_ready   (cpu_ready),
        .cpu_rvalid  (cpu_rvalid),
        .cpu_bvalid  (cpu_bvalid),
        .cpu_rdata   (cpu_rdata),
        .mem_araddr  (mem_araddr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rdata   (mem_rdata),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast),
        .mem_awaddr  (mem_awaddr),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_wdata   (mem_wdata),
        .mem_wvalid  (mem_wvalid),
        .mem_wlast   (mem_wlast),
        .mem_wready  (mem_wready),
        .mem_bvalid  (mem_bvalid)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [31:0] stim_rand();
        stim_seed = lcg_next(stim_seed);
        return {16'h0, stim_seed[31:16]};
    endfunction

    function automatic logic [31:0] mem_rand();
        mem_seed = lcg_next(mem_seed);
        return {16'h0, mem_seed[31:16]};
    endfunction

    // every address bit feeds the hash
    function automatic logic [7:0] init_byte(input logic [31:0] a);
        logic [31:0] h;
        h = lcg_next(a ^ 32'h9e3779b9);
        h = lcg_next(h ^ a);
        return h[23:16];
    endfunction

    function automatic logic [63:0] model_word(input logic [31:0] a);
        logic [63:0] w;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = model_mem.exists(a + b) ? model_mem[a + b] : init_byte(a + b);
        end
        return w;
    endfunction

    function automatic logic [63:0] bus_word(input logic [31:0] a);
        logic [63:0] w;
        for (int b = 0; b < 8; b++) begin
            w[b*8 +: 8] = bus_mem.exists(a + b) ? bus_mem[a + b] : init_byte(a + b);
        end
        return w;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    // one load or store, entered and left on a falling edge
    task automatic cache_access(input logic wr, input logic [31:0] addr,
                                input logic [63:0] wdata, input logic [7:0] mask,
                                output int lat);
        int          cnt;
        logic [63:0] exp;
        cnt = 0;
        while (!cpu_ready) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_run("cache never raised cpu_ready");
        end
        cpu_addr   = addr;
        cpu_wdata  = wdata;
        cpu_wmask  = mask;
        cpu_rd_req = !wr;
        cpu_wr_req = wr;
        exp        = model_word(addr);
        @(negedge clk);
        cpu_rd_req = 1'b0;
        cpu_wr_req = 1'b0;
        lat = 1;
        while (!(cpu_rvalid || cpu_bvalid)) begin
            @(negedge clk);
            lat++;
            if (lat > TIMEOUT) fail_run("cache gave no response to a request");
        end
        check_eq(cpu_rvalid, !wr, "cpu_rvalid on response");
        check_eq(cpu_bvalid, wr, "cpu_bvalid on response");
        check_eq(cpu_ready, 1'b0, "cpu_ready during response");
        if (wr) begin
            for (int b = 0; b < 8; b++) begin
                if (mask[b]) model_mem[addr + b] = wdata[b*8 +: 8];
            end
        end else begin
            check_eq(cpu_rdata, exp, $sformatf("load data at %h", addr));
        end
        touched[addr] = 1'b1;
        @(negedge clk);
        check_eq(cpu_ready, 1'b1, "cpu_ready after response");
    endtask

    ////////////////////////////////////////////////////////////
    // memory responder
    ////////////////////////////////////////////////////////////

    logic        r_start;
    logic        r_active;
    logic [31:0] r_addr;
    int          r_beat;
    logic [31:0] w_addr;
    int          w_beat;
    int          b_wait;

    initial begin
        mem_arready = 1'b0;
        mem_rdata   = '0;
        mem_rvalid  = 1'b0;
        mem_rlast   = 1'b0;
        mem_awready = 1'b0;
        mem_wready  = 1'b0;
        mem_bvalid  = 1'b0;
        r_start     = 1'b0;
        r_active    = 1'b0;
        r_addr      = '0;
        r_beat      = 0;
        w_addr      = '0;
        w_beat      = 0;
        b_wait      = 0;
        wb_count    = 0;
        last_wb_addr = '0;
        mem_seed    = lcg_next(32'd79);
    end

    // handshakes decided here complete on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            // read burst, one cycle after the address
            if (r_start) begin
                r_active = 1'b1;
                r_start  = 1'b0;
            end
            mem_rvalid = 1'b0;
            mem_rlast  = 1'b0;
            if (r_active && (mem_rand() % 4 != 0)) begin
                mem_rvalid = 1'b1;
                mem_rdata  = bus_word(r_addr + r_beat * 8);
                mem_rlast  = (r_beat == 3);
                r_beat++;
                if (r_beat == 4) r_active = 1'b0;
            end
            mem_arready = (mem_rand() % 3 != 0);
            if (mem_arvalid && mem_arready) begin
                check_eq(mem_araddr[4:0], 5'd0, "read address alignment");
                r_addr  = mem_araddr;
                r_beat  = 0;
                r_start = 1'b1;
            end

            // write response after a short random gap
            mem_bvalid = 1'b0;
            if (b_wait > 0) begin
                b_wait--;
                if (b_wait == 0) mem_bvalid = 1'b1;
            end
            mem_awready = (mem_rand() % 3 != 0);
            if (mem_awvalid && mem_awready) begin
                w_addr       = mem_awaddr;
                w_beat       = 0;
                wb_count++;
                last_wb_addr = mem_awaddr;
            end
            mem_wready = (mem_rand() % 3 != 0);
            if (mem_wvalid && mem_wready) begin
                // evicted data must match the latest stores
                check_eq(mem_wdata, model_word(w_addr + w_beat * 8), "write-back data");
                check_eq(mem_wlast, (w_beat == 3), "mem_wlast position");
                for (int b = 0; b < 8; b++) begin
                    bus_mem[w_addr + w_beat * 8 + b] = mem_wdata[b*8 +: 8];
                end
                w_beat++;
                if (w_beat == 4) b_wait = 1 + mem_rand() % 3;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int          cnt;
        int          lat;
        int          wb_before;
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] addr_a;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_wmask  = '0;
        cpu_rd_req = 1'b0;
        cpu_wr_req = 1'b0;
        stim_seed  = 32'd79;

        cnt = 0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_run("reset was never released");
        end

        // idle outputs after reset
        check_eq(cpu_ready, 1'b1, "cpu_ready after reset");
        check_eq(cpu_rvalid, 1'b0, "cpu_rvalid after reset");
        check_eq(cpu_bvalid, 1'b0, "cpu_bvalid after reset");
        check_eq(mem_arvalid, 1'b0, "mem_arvalid after reset");
        check_eq(mem_awvalid, 1'b0, "mem_awvalid after reset");
        check_eq(mem_wvalid, 1'b0, "mem_wvalid after reset");

        // dirty line A in way 0 is the victim of the third line in set 40
        addr_a = (32'd10 << 11) | (32'd40 << 5) | (32'd1 << 3);
        cache_access(1'b1, addr_a, 64'h0123_4567_89ab_cdef, 8'hff, lat);
        cache_access(1'b0, (32'd11 << 11) | (32'd40 << 5), '0, '0, lat);
        check_eq(wb_count, 0, "write bursts before eviction");
        wb_before = wb_count;
        cache_access(1'b0, (32'd12 << 11) | (32'd40 << 5), '0, '0, lat);
        check_eq(wb_count, wb_before + 1, "write bursts after eviction");
        check_eq(last_wb_addr, {addr_a[31:5], 5'd0}, "write-back address");

        // hit timing on a repeated read
        a = (32'd13 << 11) | (32'd41 << 5) | (32'd2 << 3);
        cache_access(1'b0, a, '0, '0, lat);
        cache_access(1'b0, a, '0, '0, lat);
        check_eq(lat, 1, "read hit latency");

        // random loads and stores over 4 sets and 4 tags
        for (int i = 0; i < 300; i++) begin
            r = stim_rand();
            a = ((1 + r[3:2]) << 11) | (r[5:4] << 5) | (r[7:6] << 3);
            if (r[0]) begin
                cache_access(1'b1, a, {stim_rand(), stim_rand()}, stim_rand(), lat);
            end else begin
                cache_access(1'b0, a, '0, '0, lat);
                if (r[9:8] == 2'd0) begin
                    cache_access(1'b0, a, '0, '0, lat);
                    check_eq(lat, 1, "read hit latency in random run");
                end
            end
        end

        // final sweep over every address used
        foreach (touched[k]) begin
            cache_access(1'b0, k, '0, '0, lat);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
dcache_geom_pkg.sv
dcache_bus_pkg.sv
dcache_data_array.sv
dcache_tag_store.sv
dcache_line_buffer.sv
dcache_wb_engine.sv
dcache_ctrl.sv
dcache_top.sv
tb_clock_gen.sv
tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_dcache -o sim_dcache

status=0
out=$(./obj_dir/sim_dcache 2>&1) || status=$?
echo "$out"

if [ "$status" -eq 0 ] && echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
